// File: Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP ?= cache_tb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= list.f
VFLAGS ?= --binary --timing
FAIL_MSG := Simulation finished: FAIL

SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/cache_addr_pkg.sv
`include "cache_cfg.svh"

package cache_addr_pkg;

   // pieces of the address
   typedef logic [`CACHE_TAG_W-1:0] tag_t;
   typedef logic [`CACHE_INDEX_W-1:0] index_t;
   typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

   // lookup view of the address
   typedef struct packed {
      tag_t tag;
      index_t index;
      offset_t offset;
   } addr_fields_t;

   // bus view, line number over the byte offset
   typedef struct packed {
      logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] line;
      offset_t offset;
   } addr_line_t;

   // same 16-bit word, decoded two ways
   typedef union packed {
      addr_fields_t f;
      addr_line_t l;
   } cache_addr_t;

   // one cache line
   typedef logic [`CACHE_LINE_W-1:0] line_data_t;

   // one enable per byte lane
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;

   // one-hot size: 1, 2, 4, 8 bytes, all zero for a whole line
   typedef logic [3:0] access_size_t;

endpackage

// File: design/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address width seen by the processor and the bus
`define CACHE_ADDR_W 16

// line geometry
`define CACHE_LINE_BYTES 16
`define CACHE_LINES 32

// address split, tag | index | offset
`define CACHE_TAG_W 7
`define CACHE_INDEX_W 5
`define CACHE_OFFSET_W 4

// one full line in bits
`define CACHE_LINE_W 128

`endif

// File: design/cache_controller.sv
`timescale 1ns/1ns

module cache_controller
(
   input  logic                       clk,
   input  logic                       reset,
   input  cache_ctrl_pkg::cache_req_t req,
   input  cache_addr_pkg::line_data_t old_line,
   input  logic                       bus_ready,
   output logic                       idle,
   output logic                       ready,
   output logic                       data_we,
   output logic                       fill_sel,
   output cache_ctrl_pkg::bus_req_t   bus
);
   import cache_addr_pkg::*;
   import cache_ctrl_pkg::*;

   cache_state_t state;
   cache_state_t state_nxt;
   logic bus_ready_q;
   logic ready_rise;
   logic hit;
   logic evict;
   logic tag_write;
   tag_t stored_tag;
   cache_addr_t bus_addr;

   cache_tag_store tags0
   (
      .clk        (clk),
      .reset      (reset),
      .index      (req.addr.f.index),
      .tag        (req.addr.f.tag),
      .tag_write  (tag_write),
      .hit        (hit),
      .evict      (evict),
      .stored_tag (stored_tag)
   );

   // previous bus_ready for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
         bus_ready_q <= 1'b0;
      else
         bus_ready_q <= bus_ready;
   end

   assign ready_rise = bus_ready && !bus_ready_q;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
            if (req.start)
               state_nxt = req.write ? LOOKUP_WR : LOOKUP_RD;
         LOOKUP_RD,
         LOOKUP_WR:
            // evict on any valid mismatch, clean or not
            if (hit)
               state_nxt = (state == LOOKUP_WR) ? HIT_WR : HIT_RD;
            else if (evict)
               state_nxt = EVICT;
            else
               state_nxt = FILL;
         HIT_RD,
         HIT_WR:
            state_nxt = IDLE;
         FILL:
            // line now present, finish as a hit
            if (ready_rise)
               state_nxt = req.write ? HIT_WR : HIT_RD;
         EVICT:
            if (ready_rise)
               state_nxt = FILL;
         default:
            state_nxt = IDLE;
      endcase
   end

   assign idle = (state == IDLE);
   assign ready = (state == HIT_RD) || (state == HIT_WR);

   // fill edge writes line, tag and valid together
   assign fill_sel = (state == FILL);
   assign tag_write = fill_sel && ready_rise;
   assign data_we = (state == HIT_WR) || tag_write;

   // old tag for write-back, request line otherwise
   always_comb
   begin
      bus_addr.l.offset = '0;
      if (state == EVICT)
         bus_addr.l.line = {stored_tag, req.addr.f.index};
      else
         bus_addr.l.line = req.addr.l.line;
   end

   assign bus.en = (state == FILL) || (state == EVICT);
   assign bus.wr = (state == EVICT);
   assign bus.addr = bus_addr;
   assign bus.wdata = old_line;

endmodule

// File: design/cache_ctrl_pkg.sv
`include "cache_cfg.svh"

package cache_ctrl_pkg;

   // controller states
   // miss and evict states serve reads and writes alike,
   // the held write flag picks the hit state after a fill
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP_RD,
      LOOKUP_WR,
      HIT_RD,
      HIT_WR,
      FILL,
      EVICT
   } cache_state_t;

   // request as the controller sees it
   // start marks a request being accepted this cycle
   typedef struct packed {
      logic start;
      logic write;
      cache_addr_pkg::cache_addr_t addr;
      cache_addr_pkg::access_size_t size;
      cache_addr_pkg::line_data_t wdata;
   } cache_req_t;

   // line-wide memory bus drive
   typedef struct packed {
      logic en;
      logic wr;
      logic [`CACHE_ADDR_W-1:0] addr;
      cache_addr_pkg::line_data_t wdata;
   } bus_req_t;

endpackage

// File: design/cache_data_array.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_data_array
(
   input  logic                       clk,
   input  cache_addr_pkg::index_t     index,
   input  cache_addr_pkg::offset_t    offset,
   input  logic                       data_we,
   input  logic                       fill_sel,
   input  cache_addr_pkg::byte_mask_t byte_mask,
   input  cache_addr_pkg::line_data_t data_write,
   input  cache_addr_pkg::line_data_t bus_read,
   output cache_addr_pkg::line_data_t line_out,
   output cache_addr_pkg::line_data_t data_read
);
   import cache_addr_pkg::*;

   line_data_t line_mem [`CACHE_LINES];
   line_data_t wr_shifted;
   line_data_t wr_line;
   byte_mask_t lane_we;
   logic [`CACHE_OFFSET_W+2:0] bit_shift;

   // offset in bytes to bits
   assign bit_shift = {offset, 3'b000};

   // processor data moved up to its byte position
   assign wr_shifted = data_write << bit_shift;

   // fill takes the bus line into every lane
   always_comb
   begin
      if (fill_sel)
      begin
         wr_line = bus_read;
         lane_we = '1;
      end
      else
      begin
         wr_line = wr_shifted;
         lane_we = byte_mask;
      end
   end

   // per-byte write enables
   always_ff @(posedge clk)
   begin
      if (data_we)
      begin
         for (int i = 0; i < `CACHE_LINE_BYTES; i++)
         begin
            if (lane_we[i])
               line_mem[index][i*8 +: 8] <= wr_line[i*8 +: 8];
         end
      end
   end

   // raw line for write-back
   assign line_out = line_mem[index];

   // addressed byte down to lane 0, zeros shifted in on top
   assign data_read = line_out >> bit_shift;

endmodule

// File: design/cache_request_decode.sv
`timescale 1ns/1ns

module cache_request_decode
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         idle,
   input  logic                         enable,
   input  logic                         rw,
   input  cache_addr_pkg::cache_addr_t  addr,
   input  cache_addr_pkg::access_size_t size,
   input  cache_addr_pkg::line_data_t   data_write,
   output cache_ctrl_pkg::cache_req_t   req,
   output cache_addr_pkg::byte_mask_t   byte_mask
);
   import cache_addr_pkg::*;

   logic write_q;
   cache_addr_t addr_q;
   access_size_t size_q;
   line_data_t wdata_q;
   byte_mask_t size_run;

   // capture on the accepting edge only
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         write_q <= 1'b0;
      end
      else if (idle && enable)
      begin
         write_q <= rw;
         addr_q <= addr;
         size_q <= size;
         wdata_q <= data_write;
      end
   end

   // live request while idle so the FSM can leave IDLE on the same edge
   // held copy for the rest of the access
   always_comb
   begin
      if (idle)
      begin
         req.start = enable;
         req.write = rw;
         req.addr = addr;
         req.size = size;
         req.wdata = data_write;
      end
      else
      begin
         req.start = 1'b0;
         req.write = write_q;
         req.addr = addr_q;
         req.size = size_q;
         req.wdata = wdata_q;
      end
   end

   // run of ones for the access size
   always_comb
   begin
      if (size_q[0])
         size_run = 16'h0001;
      else if (size_q[1])
         size_run = 16'h0003;
      else if (size_q[2])
         size_run = 16'h000f;
      else if (size_q[3])
         size_run = 16'h00ff;
      else
         size_run = 16'hffff;
   end

   // lanes pushed past byte 15 fall off the top
   assign byte_mask = size_run << addr_q.f.offset;

endmodule

// File: design/cache_tag_store.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_tag_store
(
   input  logic                   clk,
   input  logic                   reset,
   input  cache_addr_pkg::index_t index,
   input  cache_addr_pkg::tag_t   tag,
   input  logic                   tag_write,
   output logic                   hit,
   output logic                   evict,
   output cache_addr_pkg::tag_t   stored_tag
);
   import cache_addr_pkg::*;

   tag_t tag_mem [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] valid;
   logic line_valid;
   logic tag_match;

   // tag array
   always_ff @(posedge clk)
   begin
      if (tag_write)
         tag_mem[index] <= tag;
   end

   // valid bits kept apart so reset can clear them all
   always_ff @(posedge clk)
   begin
      if (reset)
         valid <= '0;
      else if (tag_write)
         valid[index] <= 1'b1;
   end

   // compare against the addressed entry
   assign stored_tag = tag_mem[index];
   assign line_valid = valid[index];
   assign tag_match = (stored_tag == tag);

   assign hit = line_valid && tag_match;
   // a different line occupies the slot
   assign evict = line_valid && !tag_match;

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_top
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         enable,
   input  logic                         rw,
   input  cache_addr_pkg::cache_addr_t  addr,
   input  cache_addr_pkg::access_size_t size,
   input  cache_addr_pkg::line_data_t   data_write,
   output cache_addr_pkg::line_data_t   data_read,
   output logic                         ready,
   output logic                         bus_en,
   output logic                         bus_wr,
   output logic [`CACHE_ADDR_W-1:0]     bus_addr,
   output cache_addr_pkg::line_data_t   bus_write,
   input  logic                         bus_ready,
   input  cache_addr_pkg::line_data_t   bus_read
);
   import cache_addr_pkg::*;
   import cache_ctrl_pkg::*;

   cache_req_t req;
   byte_mask_t byte_mask;
   logic idle;
   logic data_we;
   logic fill_sel;
   line_data_t line_out;
   bus_req_t bus;

   cache_request_decode decode0
   (
      .clk        (clk),
      .reset      (reset),
      .idle       (idle),
      .enable     (enable),
      .rw         (rw),
      .addr       (addr),
      .size       (size),
      .data_write (data_write),
      .req        (req),
      .byte_mask  (byte_mask)
   );

   cache_controller ctrl0
   (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .old_line  (line_out),
      .bus_ready (bus_ready),
      .idle      (idle),
      .ready     (ready),
      .data_we   (data_we),
      .fill_sel  (fill_sel),
      .bus       (bus)
   );

   cache_data_array data0
   (
      .clk        (clk),
      .index      (req.addr.f.index),
      .offset     (req.addr.f.offset),
      .data_we    (data_we),
      .fill_sel   (fill_sel),
      .byte_mask  (byte_mask),
      .data_write (req.wdata),
      .bus_read   (bus_read),
      .line_out   (line_out),
      .data_read  (data_read)
   );

   // bus struct out to pins
   assign bus_en = bus.en;
   assign bus_wr = bus.wr;
   assign bus_addr = bus.addr;
   assign bus_write = bus.wdata;

endmodule

// File: list.f
+incdir+design
design/cache_addr_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_request_decode.sv
design/cache_tag_store.sv
design/cache_controller.sv
design/cache_data_array.sv
design/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

// File: tests/cache_checker.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_checker
(
   input logic                             clk,
   input logic                             reset,
   input logic                             ready,
   input cache_addr_pkg::line_data_t       data_read,
   input logic                             bus_en,
   input logic                             bus_wr,
   input logic [`CACHE_ADDR_W-1:0]         bus_addr,
   input cache_addr_pkg::line_data_t       bus_write,
   input logic                             bus_ready
);
   import cache_addr_pkg::*;

   // expectations of the entry in flight
   string cur_name;
   logic active = 1'b0;
   logic started = 1'b0;
   logic cur_read;
   logic cur_hit;
   line_data_t cur_exp_read;
   logic [15:0] cur_fill_addr;
   logic cur_wb_valid;
   logic [15:0] cur_wb_addr;
   line_data_t cur_wb_data;

   int cycles;
   int fills;
   int wbacks;
   int entry_errors;
   int errors = 0;
   int passed = 0;
   int entries_done = 0;
   logic ready_prev = 1'b0;

   task automatic begin_entry(input string name, input logic is_read, input logic hit,
                              input line_data_t exp_read, input logic [15:0] fill_addr,
                              input logic wb_valid, input logic [15:0] wb_addr,
                              input line_data_t wb_data);
      cur_name = name;
      cur_read = is_read;
      cur_hit = hit;
      cur_exp_read = exp_read;
      cur_fill_addr = fill_addr;
      cur_wb_valid = wb_valid;
      cur_wb_addr = wb_addr;
      cur_wb_data = wb_data;
      cycles = 0;
      fills = 0;
      wbacks = 0;
      entry_errors = 0;
      active = 1'b1;
      started = 1'b1;
   endtask

   function automatic int error_count();
      return errors;
   endfunction

   task automatic print_summary();
      $display("entries %0d, passed %0d, errors %0d", entries_done, passed, errors);
   endtask

   task automatic flag(input string msg);
      $display("%s", msg);
      errors++;
      entry_errors++;
   endtask

   always @(posedge clk)
   begin
      // outputs stay quiet from reset until the first request
      if (!reset && !started && (ready !== 1'b0 || bus_en !== 1'b0 || bus_wr !== 1'b0))
         flag("error: ready or bus drive active before the first request");
      if (!reset && !active && started && ready)
         flag("error: ready seen with no request in flight");

      if (active)
      begin
         cycles++;
         // a hit leaves the bus alone
         if (cur_hit && bus_en !== 1'b0)
            flag($sformatf("error: %s drove the bus on a hit", cur_name));
         // a rising bus_ready is one completed bus transfer
         if (bus_en && bus_ready && !ready_prev)
         begin
            if (bus_wr)
            begin
               wbacks++;
               if (!cur_wb_valid)
                  flag($sformatf("error: %s made an unexpected bus write", cur_name));
               else
               begin
                  if (bus_addr !== cur_wb_addr)
                     flag($sformatf("mismatch %s wb_addr expected %h actual %h",
                                    cur_name, cur_wb_addr, bus_addr));
                  if (bus_write !== cur_wb_data)
                     flag($sformatf("mismatch %s wb_data expected %h actual %h",
                                    cur_name, cur_wb_data, bus_write));
               end
            end
            else
            begin
               fills++;
               if (bus_addr !== cur_fill_addr)
                  flag($sformatf("mismatch %s fill_addr expected %h actual %h",
                                 cur_name, cur_fill_addr, bus_addr));
            end
         end

         if (ready)
         begin
            if (cur_read && data_read !== cur_exp_read)
               flag($sformatf("mismatch %s read expected %h actual %h",
                              cur_name, cur_exp_read, data_read));
            // a hit finishes in the second cycle after the accepting edge
            if (cur_hit && cycles != 3)
               flag($sformatf("mismatch %s ready_cycle expected 2 actual %0d",
                              cur_name, cycles - 1));
            if (fills != (cur_hit ? 0 : 1))
               flag($sformatf("mismatch %s bus_reads expected %0d actual %0d",
                              cur_name, cur_hit ? 0 : 1, fills));
            if (cur_wb_valid && wbacks != 1)
               flag($sformatf("error: %s expected one write-back, saw %0d", cur_name, wbacks));
            if (entry_errors == 0)
            begin
               passed++;
               $display("entry %s ok", cur_name);
            end
            else
               $display("entry %s failed", cur_name);
            entries_done++;
            active = 1'b0;
         end
      end
      ready_prev = bus_ready;
   end

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_tb;
   import cache_addr_pkg::*;

   localparam int NUM = 11;

   typedef struct packed {
      logic rw;
      logic hit;
      logic [15:0] addr;
      logic [3:0] size;
      line_data_t data;
      line_data_t exp_read;
      logic wb_valid;
      logic [15:0] wb_addr;
      line_data_t wb_data;
   } entry_t;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic enable = 1'b0;
   logic rw = 1'b0;
   cache_addr_t addr = '0;
   access_size_t size = '0;
   line_data_t data_write = '0;
   line_data_t data_read;
   logic ready;
   logic bus_en;
   logic bus_wr;
   logic [15:0] bus_addr;
   line_data_t bus_write;
   logic bus_ready = 1'b0;
   line_data_t bus_read = '0;

   entry_t table_e [NUM];
   string names [NUM];
   int n_entries = 0;

   // memory model state
   logic [7:0] mem [65536];
   logic [31:0] lfsr = 32'hc95b028e;
   logic serving = 1'b0;
   logic serving_wr = 1'b0;
   int wait_left = 0;

   cache_top dut0
   (
      .clk(clk), .reset(reset), .enable(enable), .rw(rw), .addr(addr), .size(size),
      .data_write(data_write), .data_read(data_read), .ready(ready),
      .bus_en(bus_en), .bus_wr(bus_wr), .bus_addr(bus_addr), .bus_write(bus_write),
      .bus_ready(bus_ready), .bus_read(bus_read)
   );

   cache_checker chk0
   (
      .clk(clk), .reset(reset), .ready(ready), .data_read(data_read),
      .bus_en(bus_en), .bus_wr(bus_wr), .bus_addr(bus_addr), .bus_write(bus_write),
      .bus_ready(bus_ready)
   );

   always #10 clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], b};
      return b;
   endfunction

   // 1 to 8 cycles from three bits
   task automatic next_delay(output int d);
      logic [2:0] r;
      r[0] = lfsr_bit();
      r[1] = lfsr_bit();
      r[2] = lfsr_bit();
      d = int'(r) + 1;
   endtask

   task automatic add(input string name, input logic w, input logic hit, input logic [15:0] a,
                      input logic [3:0] sz, input line_data_t d, input line_data_t exp_rd,
                      input logic wbv, input logic [15:0] wba, input line_data_t wbd);
      names[n_entries] = name;
      table_e[n_entries] = '{w, hit, a, sz, d, exp_rd, wbv, wba, wbd};
      n_entries++;
   endtask

   // bus memory, ready after a random delay, dropped when bus_en falls or bus_wr turns
   always @(negedge clk)
   begin
      if (reset || !bus_en)
      begin
         bus_ready <= 1'b0;
         serving = 1'b0;
      end
      else if (!serving || bus_wr != serving_wr)
      begin
         serving = 1'b1;
         serving_wr = bus_wr;
         bus_ready <= 1'b0;
         next_delay(wait_left);
      end
      else if (!bus_ready)
      begin
         if (wait_left > 1)
            wait_left--;
         else
         begin
            for (int i = 0; i < `CACHE_LINE_BYTES; i++)
            begin
               if (bus_wr)
                  mem[bus_addr + 16'(i)] = bus_write[i*8 +: 8];
               else
                  bus_read[i*8 +: 8] <= mem[bus_addr + 16'(i)];
            end
            bus_ready <= 1'b1;
         end
      end
   end

   initial
   begin
      #((NUM * 40 + 100) * 20);
      $display("timeout: the cache stopped answering before all entries finished");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      // byte at a is low byte xor high byte
      for (int a = 0; a < 65536; a++)
         mem[a] = 8'(a) ^ 8'(a >> 8);

      add("cold_rd", 0, 0, 16'h0045, 4'h1, '0, 128'h00000000004f4e4d4c4b4a4948474645,
          0, '0, '0);
      add("hit_rd", 0, 1, 16'h0040, 4'h0, '0, 128'h4f4e4d4c4b4a49484746454443424140,
          0, '0, '0);
      add("wr_b1", 1, 1, 16'h0043, 4'h1, 128'haa, '0, 0, '0, '0);
      add("wr_b2", 1, 1, 16'h0046, 4'h2, 128'hbbcc, '0, 0, '0, '0);
      add("wr_b4", 1, 1, 16'h0048, 4'h4, 128'h11223344, '0, 0, '0, '0);
      add("wr_b8", 1, 1, 16'h004c, 4'h8, 128'h8877665544332211, '0, 0, '0, '0);
      add("rd_merged", 0, 1, 16'h0040, 4'h0, '0, 128'h4433221111223344bbcc4544aa424140,
          0, '0, '0);
      add("other_idx", 0, 0, 16'h1235, 4'h0, '0, 128'h00000000002d2c2f2e29282b2a252427,
          0, '0, '0);
      add("evict_rd", 0, 0, 16'h0240, 4'h0, '0, 128'h4d4c4f4e49484b4a4544474641404342,
          1, 16'h0040, 128'h4433221111223344bbcc4544aa424140);
      add("wr_full", 1, 1, 16'h0240, 4'h0, 128'h00112233445566778899aabbccddeeff, '0,
          0, '0, '0);
      add("reload_rd", 0, 0, 16'h0041, 4'h0, '0, 128'h004433221111223344bbcc4544aa4241,
          1, 16'h0240, 128'h00112233445566778899aabbccddeeff);

      repeat (8) @(negedge clk);
      reset = 1'b0;
      // idle outputs watched by the checker here
      repeat (3) @(negedge clk);

      for (int i = 0; i < n_entries; i++)
      begin
         enable = 1'b1;
         rw = table_e[i].rw;
         addr = table_e[i].addr;
         size = table_e[i].size;
         data_write = table_e[i].data;
         chk0.begin_entry(names[i], !table_e[i].rw, table_e[i].hit, table_e[i].exp_read,
                          {table_e[i].addr[15:4], 4'h0}, table_e[i].wb_valid,
                          table_e[i].wb_addr, table_e[i].wb_data);
         @(negedge clk);
         // request is latched, the inputs may wander now
         enable = 1'b0;
         addr = '0;
         data_write = '1;
         while (!ready)
            @(negedge clk);
         @(negedge clk);
      end

      chk0.print_summary();
      if (chk0.error_count() == 0 && chk0.entries_done == n_entries)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
